//--- source/dram_macros.svh
// Array geometry, field widths, command codes, latency and refresh interval
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

`define DRAM_NUM_BANKS 4
`define DRAM_NUM_ROWS 32
`define DRAM_NUM_COLS 8

`define DRAM_BANK_W 2
`define DRAM_ROW_W 5
`define DRAM_COL_W 3
`define DRAM_ADDR_W 10
`define DRAM_DATA_W 16

`define DRAM_CMD_ACT 2'b00
`define DRAM_CMD_REF 2'b10
`define DRAM_CMD_PRE 2'b11

`define DRAM_CMD_LAT 3            // cmd_req rise to cmd_ack pulse
`define DRAM_REFRESH_INTERVAL 60

`endif

//--- source/dram_pkg.sv
// Address word union, linear index or bank/row/col fields
`default_nettype none
`include "dram_macros.svh"

package dram_pkg;

    // Fields are bank, row, col from the top, so the linear view is row-major
    typedef union packed {
        logic [`DRAM_ADDR_W-1:0] linear;
        struct packed {
            logic [`DRAM_BANK_W-1:0] bank;
            logic [`DRAM_ROW_W-1:0]  row;
            logic [`DRAM_COL_W-1:0]  col;
        } f;
    } dram_addr_u;

endpackage

`default_nettype wire

//--- source/dram_ctrl_fsm.sv
// Activate, column stream, precharge and refresh sequencing FSM
`default_nettype none
`include "dram_macros.svh"

module dram_ctrl_fsm (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 addr_val,
    input  logic                 refresh_flag,
    input  logic                 cmd_ack,
    input  logic [`DRAM_ROW_W:0] row_count,
    output logic                 row_inc,
    output logic                 col_inc,
    output logic                 cmd_req,
    output logic [1:0]           cmd,
    output logic                 row_en,
    output logic                 col_en,
    output logic                 bank_en,
    output logic                 address_buff_en,
    output logic                 bank_rw,
    output logic                 buf_rw,
    output logic                 refresh_ack,
    output logic                 busy,
    output logic                 done
);

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] BNR       = 3'd1;
    localparam logic [2:0] COL       = 3'd2;
    localparam logic [2:0] PRECHARGE = 3'd3;
    localparam logic [2:0] REFRESH   = 3'd4;

    localparam int RC_W  = `DRAM_ROW_W + 1;
    localparam int COL_W = `DRAM_COL_W;

    logic [2:0]       state;
    logic [2:0]       next_state;
    logic [2:0]       ret_state;      // Where to go once refresh is done
    logic [2:0]       next_ret_state;
    logic [COL_W-1:0] col_cnt;
    logic [RC_W-1:0]  rows_left;
    logic [RC_W-1:0]  next_rows_left;
    logic             issue;
    logic             divert;
    logic             last_row;

    // Refresh may only cut in before a command is raised
    assign divert   = refresh_flag && !cmd_req;
    assign last_row = (rows_left == RC_W'(1));
    assign busy     = (state != IDLE);

    always_comb begin
        next_state      = state;
        next_ret_state  = ret_state;
        next_rows_left  = rows_left;
        issue           = 1'b0;
        cmd             = `DRAM_CMD_ACT;
        row_en          = 1'b0;
        col_en          = 1'b0;
        bank_en         = 1'b0;
        bank_rw         = 1'b0;
        buf_rw          = 1'b0;
        row_inc         = 1'b0;
        col_inc         = 1'b0;
        address_buff_en = 1'b0;
        refresh_ack     = 1'b0;

        case (state)
            IDLE: begin
                if (addr_val) begin
                    address_buff_en = 1'b1;
                    next_rows_left  = row_count;
                    next_state      = BNR;
                end
            end

            BNR: begin
                bank_en = 1'b1;
                row_en  = 1'b1;
                buf_rw  = 1'b1;   // Row lands in the row buffer
                if (divert) begin
                    next_ret_state = BNR;
                    next_state     = REFRESH;
                end else if (cmd_ack) begin
                    next_state = COL;
                end else begin
                    issue = 1'b1;
                end
            end

            COL: begin
                col_en  = 1'b1;
                col_inc = 1'b1;
                if (col_cnt == COL_W'(`DRAM_NUM_COLS - 1)) begin
                    if (refresh_flag) begin
                        next_ret_state = PRECHARGE;
                        next_state     = REFRESH;
                    end else begin
                        next_state = PRECHARGE;
                    end
                end
            end

            PRECHARGE: begin
                cmd     = `DRAM_CMD_PRE;
                bank_en = 1'b1;
                bank_rw = 1'b1;   // Buffer goes back to the bank
                if (divert) begin
                    next_ret_state = PRECHARGE;
                    next_state     = REFRESH;
                end else if (cmd_ack) begin
                    row_inc        = 1'b1;
                    next_rows_left = rows_left - RC_W'(1);
                    next_state     = last_row ? IDLE : BNR;
                end else begin
                    issue = 1'b1;
                end
            end

            REFRESH: begin
                cmd = `DRAM_CMD_REF;
                if (cmd_ack) begin
                    refresh_ack = 1'b1;
                    next_state  = ret_state;
                end else begin
                    issue = 1'b1;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state     <= IDLE;
            ret_state <= IDLE;
            rows_left <= '0;
            col_cnt   <= '0;
            cmd_req   <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= next_state;
            ret_state <= next_ret_state;
            rows_left <= next_rows_left;
            cmd_req   <= issue;
            done      <= (state == PRECHARGE) && cmd_ack && last_row;
            if (state == COL) begin
                col_cnt <= col_cnt + COL_W'(1);   // Wraps to 0 after the last column
            end
        end
    end

    // Request held until the array answers
    assert property (@(posedge clk) disable iff (!rst_b)
        cmd_req && !cmd_ack |=> cmd_req);

    // Host has to wait for done before the next start
    assert property (@(posedge clk) disable iff (!rst_b) addr_val |-> !busy);

endmodule

`default_nettype wire

//--- source/dram_refresh_timer.sv
// Refresh interval counter with flag held until acknowledge
`default_nettype none
`include "dram_macros.svh"

module dram_refresh_timer (
    input  logic clk,
    input  logic rst_b,
    input  logic refresh_ack,
    output logic refresh_flag
);

    localparam int CNT_W = $clog2(`DRAM_REFRESH_INTERVAL);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            count        <= '0;
            refresh_flag <= 1'b0;
        end else if (refresh_ack) begin
            count        <= CNT_W'(1);   // Ack cycle counts as the first
            refresh_flag <= 1'b0;
        end else if (!refresh_flag) begin
            if (count == CNT_W'(`DRAM_REFRESH_INTERVAL - 1)) begin
                refresh_flag <= 1'b1;
            end else begin
                count <= count + CNT_W'(1);
            end
        end
    end

    // FSM only answers a pending request
    assert property (@(posedge clk) disable iff (!rst_b) refresh_ack |-> refresh_flag);

endmodule

`default_nettype wire

//--- source/dram_addr_buffer.sv
// Current bank, row and column register with load and stepping
`default_nettype none
`include "dram_macros.svh"

module dram_addr_buffer (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 address_buff_en,
    input  dram_pkg::dram_addr_u start_addr,
    input  logic                 row_inc,
    input  logic                 col_inc,
    output dram_pkg::dram_addr_u cur_addr
);

    import dram_pkg::*;

    localparam int BR_W  = `DRAM_BANK_W + `DRAM_ROW_W;
    localparam int COL_W = `DRAM_COL_W;

    dram_addr_u next_addr;

    always_comb begin
        next_addr = cur_addr;
        if (address_buff_en) begin
            // Streams always begin at column 0
            next_addr.linear = {start_addr.f.bank, start_addr.f.row, COL_W'(0)};
        end else if (row_inc) begin
            {next_addr.f.bank, next_addr.f.row} =
                {cur_addr.f.bank, cur_addr.f.row} + BR_W'(1);   // Last row carries into bank
        end else if (col_inc) begin
            next_addr.f.col = cur_addr.f.col + COL_W'(1);       // Wraps inside the row
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cur_addr <= '0;
        end else begin
            cur_addr <= next_addr;
        end
    end

    // Column stepping finishes a row before the row moves on
    assert property (@(posedge clk) disable iff (!rst_b)
        row_inc |-> cur_addr.f.col == '0);

endmodule

`default_nettype wire

//--- source/dram_bank_array.sv
// Behavioural banks with row buffers, command responder and host load port
`default_nettype none
`include "dram_macros.svh"

module dram_bank_array (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic [1:0]              cmd,
    input  logic                    cmd_req,
    input  logic                    bank_en,
    input  logic                    row_en,
    input  logic                    col_en,
    input  logic                    bank_rw,
    input  logic                    buf_rw,
    input  dram_pkg::dram_addr_u    cur_addr,
    input  logic                    load_en,
    input  dram_pkg::dram_addr_u    load_addr,
    input  logic [`DRAM_DATA_W-1:0] load_data,
    output logic                    cmd_ack,
    output logic [`DRAM_DATA_W-1:0] rd_data,
    output logic                    rd_val
);

    import dram_pkg::*;

    localparam int WORDS = `DRAM_NUM_BANKS * `DRAM_NUM_ROWS * `DRAM_NUM_COLS;
    localparam int COL_W = `DRAM_COL_W;
    localparam int LAT_W = $clog2(`DRAM_CMD_LAT + 1);

    logic [`DRAM_DATA_W-1:0]   mem [WORDS];
    logic [`DRAM_DATA_W-1:0]   row_buf [`DRAM_NUM_BANKS][`DRAM_NUM_COLS];
    logic [`DRAM_NUM_BANKS-1:0] row_open;
    logic [LAT_W-1:0]          lat_cnt;
    logic                      do_act;
    logic                      do_pre;

    // Data moves only on the acknowledge cycle
    assign do_act = cmd_ack && (cmd == `DRAM_CMD_ACT) && bank_en && row_en && buf_rw;
    assign do_pre = cmd_ack && (cmd == `DRAM_CMD_PRE) && bank_en && bank_rw;

    // Fixed latency responder with no data action on refresh
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lat_cnt <= '0;
            cmd_ack <= 1'b0;
        end else if (cmd_ack) begin
            lat_cnt <= '0;
            cmd_ack <= 1'b0;
        end else if (cmd_req) begin
            if (lat_cnt == LAT_W'(`DRAM_CMD_LAT - 1)) begin
                lat_cnt <= '0;
                cmd_ack <= 1'b1;
            end else begin
                lat_cnt <= lat_cnt + LAT_W'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            row_open <= '0;
            rd_val   <= 1'b0;
        end else begin
            rd_val <= col_en;
            if (do_act) begin
                row_open[cur_addr.f.bank] <= 1'b1;
            end else if (do_pre) begin
                row_open[cur_addr.f.bank] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        dram_addr_u word_addr;
        word_addr = cur_addr;
        if (load_en) begin
            mem[load_addr.linear] <= load_data;
        end
        // Whole row moves between storage and buffer in one cycle
        for (int c = 0; c < `DRAM_NUM_COLS; c++) begin
            word_addr.f.col = COL_W'(c);
            if (do_act) begin
                row_buf[cur_addr.f.bank][word_addr.f.col] <= mem[word_addr.linear];
            end
            if (do_pre) begin
                mem[word_addr.linear] <= row_buf[cur_addr.f.bank][word_addr.f.col];
            end
        end
        if (col_en) begin
            rd_data <= row_buf[cur_addr.f.bank][cur_addr.f.col];
        end
    end

    // Stream reads only from an activated row
    assert property (@(posedge clk) disable iff (!rst_b)
        col_en |-> row_open[cur_addr.f.bank]);

    // Load into an open bank would be lost at write-back
    assert property (@(posedge clk) disable iff (!rst_b)
        load_en |-> !row_open[load_addr.f.bank]);

endmodule

`default_nettype wire

//--- source/dram_subsystem.sv
// DRAM read controller top with FSM, refresh timer, address buffer and banks
`default_nettype none
`include "dram_macros.svh"

module dram_subsystem (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    addr_val,
    input  dram_pkg::dram_addr_u    start_addr,
    input  logic [`DRAM_ROW_W:0]    row_count,
    input  logic                    load_en,
    input  dram_pkg::dram_addr_u    load_addr,
    input  logic [`DRAM_DATA_W-1:0] load_data,
    output logic [`DRAM_DATA_W-1:0] rd_data,
    output logic                    rd_val,
    output logic                    busy,
    output logic                    done,
    output logic [1:0]              cmd,
    output logic                    cmd_ack
);

    import dram_pkg::*;

    logic       refresh_flag;
    logic       refresh_ack;
    logic       cmd_req;
    logic       row_inc;
    logic       col_inc;
    logic       row_en;
    logic       col_en;
    logic       bank_en;
    logic       address_buff_en;
    logic       bank_rw;
    logic       buf_rw;
    dram_addr_u cur_addr;

    dram_ctrl_fsm dram_ctrl_fsm_inst (
        .clk             (clk),
        .rst_b           (rst_b),
        .addr_val        (addr_val),
        .refresh_flag    (refresh_flag),
        .cmd_ack         (cmd_ack),
        .row_count       (row_count),
        .row_inc         (row_inc),
        .col_inc         (col_inc),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .row_en          (row_en),
        .col_en          (col_en),
        .bank_en         (bank_en),
        .address_buff_en (address_buff_en),
        .bank_rw         (bank_rw),
        .buf_rw          (buf_rw),
        .refresh_ack     (refresh_ack),
        .busy            (busy),
        .done            (done)
    );

    dram_refresh_timer dram_refresh_timer_inst (
        .clk          (clk),
        .rst_b        (rst_b),
        .refresh_ack  (refresh_ack),
        .refresh_flag (refresh_flag)
    );

    dram_addr_buffer dram_addr_buffer_inst (
        .clk             (clk),
        .rst_b           (rst_b),
        .address_buff_en (address_buff_en),
        .start_addr      (start_addr),
        .row_inc         (row_inc),
        .col_inc         (col_inc),
        .cur_addr        (cur_addr)
    );

    dram_bank_array dram_bank_array_inst (
        .clk       (clk),
        .rst_b     (rst_b),
        .cmd       (cmd),
        .cmd_req   (cmd_req),
        .bank_en   (bank_en),
        .row_en    (row_en),
        .col_en    (col_en),
        .bank_rw   (bank_rw),
        .buf_rw    (buf_rw),
        .cur_addr  (cur_addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .cmd_ack   (cmd_ack),
        .rd_data   (rd_data),
        .rd_val    (rd_val)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// Testbench clock and active low reset source
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_b
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_b = 1'b1;   // Released just after the edge
    end

endmodule

`default_nettype wire

//--- sim/tb_dram_subsystem.sv
// Data-driven testbench for the DRAM read controller with stream, refresh and idle checks
`default_nettype none
`include "dram_macros.svh"

module tb_dram_subsystem;

    import dram_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DLY    = 2;
    localparam int NUM_WORDS    = `DRAM_NUM_BANKS * `DRAM_NUM_ROWS * `DRAM_NUM_COLS;
    localparam int MAX_TESTS    = 32;
    localparam int REC_W        = 4;    // bank, row, row count, word count
    localparam int CYC_PER_ROW  = 40;
    localparam int IDLE_GAP     = 4;
    localparam int RC_W         = `DRAM_ROW_W + 1;

    logic                    clk;
    logic                    rst_b;
    logic                    addr_val;
    dram_addr_u              start_addr;
    logic [RC_W-1:0]         row_count;
    logic                    load_en;
    dram_addr_u              load_addr;
    logic [`DRAM_DATA_W-1:0] load_data;
    logic [`DRAM_DATA_W-1:0] rd_data;
    logic                    rd_val;
    logic                    busy;
    logic                    done;
    logic [1:0]              cmd;
    logic                    cmd_ack;

    logic [31:0]             test_words [MAX_TESTS*REC_W];
    logic [`DRAM_DATA_W-1:0] shadow [NUM_WORDS];
    logic [31:0]             rng_state;
    dram_addr_u              addr_q [$];   // Addresses of column reads not yet returned
    dram_addr_u              exp_start;
    int                      num_tests;
    int                      error_count;
    int                      tests_passed;
    int                      tests_failed;
    int                      cycle;
    int                      word_idx;
    int                      last_rd_cycle;
    int                      last_ref_cycle;
    int                      ref_count;
    bit                      in_test;
    bit                      done_seen;
    bit                      have_ref;
    bit                      tests_ready;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
        .clk   (clk),
        .rst_b (rst_b)
    );

    dram_subsystem dram_subsystem_inst (
        .clk        (clk),
        .rst_b      (rst_b),
        .addr_val   (addr_val),
        .start_addr (start_addr),
        .row_count  (row_count),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_data    (rd_data),
        .rd_val     (rd_val),
        .busy       (busy),
        .done       (done),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_data(input string name, input logic [`DRAM_DATA_W-1:0] got,
                              input logic [`DRAM_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input dram_addr_u got, input dram_addr_u exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got b%0d r%0d c%0d expected b%0d r%0d c%0d",
                     $time, name, got.f.bank, got.f.row, got.f.col,
                     exp.f.bank, exp.f.row, exp.f.col);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Called once per cycle at the falling edge, where every output is settled
    task automatic sample_outputs();
        dram_addr_u exp_addr;
        dram_addr_u got_addr;
        cycle++;
        if (rd_val) begin
            if (!in_test) begin
                report_error("rd_val high while the controller is idle");
            end else begin
                exp_addr.linear = exp_start.linear + `DRAM_ADDR_W'(word_idx);   // Row-major walk
                if (addr_q.size() == 0) begin
                    report_error("read data returned without a column read");
                end else begin
                    got_addr = addr_q.pop_front();
                    check_addr("cur_addr", got_addr, exp_addr);
                end
                check_data("rd_data", rd_data, shadow[exp_addr.linear]);
                if ((word_idx % `DRAM_NUM_COLS) != 0 && cycle != last_rd_cycle + 1) begin
                    report_error("gap in the word stream inside a row");
                end
                last_rd_cycle = cycle;
                word_idx++;
            end
        end
        if (dram_subsystem_inst.col_en) begin
            addr_q.push_back(dram_subsystem_inst.cur_addr);
        end
        if (cmd_ack && cmd == `DRAM_CMD_REF) begin
            if (have_ref && (cycle - last_ref_cycle) < `DRAM_REFRESH_INTERVAL) begin
                report_error($sformatf("refresh acknowledges only %0d cycles apart",
                                       cycle - last_ref_cycle));
            end
            have_ref       = 1'b1;
            last_ref_cycle = cycle;
            ref_count++;
        end
        if (done) begin
            if (!in_test) begin
                report_error("done pulse without a running test");
            end
            check_bit("busy", busy, 1'b0);
            done_seen = 1'b1;
            in_test   = 1'b0;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic load_array();
        for (int i = 0; i < NUM_WORDS; i++) begin
            rng_state        = xorshift32(rng_state);
            shadow[i]        = rng_state[`DRAM_DATA_W-1:0];
            load_en          = 1'b1;
            load_addr.linear = `DRAM_ADDR_W'(i);
            load_data        = shadow[i];
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic run_test(input int idx);
        int errs_before;
        int refs_before;
        int exp_words;
        errs_before = error_count;
        refs_before = ref_count;
        exp_words   = int'(test_words[idx*REC_W+3]);
        rng_state   = xorshift32(rng_state);

        start_addr.f.bank = `DRAM_BANK_W'(test_words[idx*REC_W]);
        start_addr.f.row  = `DRAM_ROW_W'(test_words[idx*REC_W+1]);
        start_addr.f.col  = rng_state[`DRAM_COL_W-1:0];   // Random column that the load ignores
        row_count         = RC_W'(test_words[idx*REC_W+2]);
        exp_start         = start_addr;
        exp_start.f.col   = '0;
        word_idx          = 0;
        done_seen         = 1'b0;
        in_test           = 1'b1;
        addr_q.delete();
        addr_val = 1'b1;
        next_cycle();
        addr_val = 1'b0;
        check_bit("busy", busy, 1'b1);

        while (!done_seen) begin
            next_cycle();
        end
        if (word_idx != exp_words) begin
            report_error($sformatf("test %0d streamed %0d words, expected %0d",
                                   idx, word_idx, exp_words));
        end
        repeat (IDLE_GAP) next_cycle();
        check_bit("busy", busy, 1'b0);

        if (error_count == errs_before) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d bank %0d row %0d rows %0d words %0d refreshes %0d: %s",
                 idx, exp_start.f.bank, exp_start.f.row, row_count, word_idx,
                 ref_count - refs_before, (error_count == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        addr_val     = 1'b0;
        start_addr   = '0;
        row_count    = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        rng_state    = 32'ha689;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle        = 0;
        ref_count    = 0;
        have_ref     = 1'b0;
        in_test      = 1'b0;
        for (int i = 0; i < MAX_TESTS * REC_W; i++) begin
            test_words[i] = '0;
        end
        $readmemh("sim/dram_tests.txt", test_words);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_words[num_tests*REC_W+2] != 32'd0) begin
            num_tests++;
        end
        tests_ready = 1'b1;

        wait (rst_b);
        @(posedge clk);
        #DRIVE_DLY;
        load_array();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        if (num_tests == 0) begin
            report_error("no test records read from sim/dram_tests.txt");
        end
        if (ref_count == 0) begin
            report_error("no refresh acknowledge seen during the streams");
        end
        $display("Tests run %0d, passed %0d, failed %0d, refreshes %0d, errors %0d",
                 num_tests, tests_passed, tests_failed, ref_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Budget grows with the rows streamed
    initial begin : watchdog
        int budget;
        wait (tests_ready);
        budget = RESET_CYCLES + NUM_WORDS + 20;
        for (int t = 0; t < num_tests; t++) begin
            budget += int'(test_words[t*REC_W+2]) * CYC_PER_ROW;
        end
        #(budget * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test never finished", budget);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dram_tests.txt
// DRAM stream tests, one record per line, every field in hex
// Columns: start bank, start row, row count, expected word count
// A record with row count 0 ends the list

// Single rows and short runs
0 00 01 08
0 05 04 20
3 1f 01 08

// Last row of a bank into row 0 of the next bank
0 1f 03 18
1 1e 04 20
2 1f 02 10

// Long runs, several refreshes fall inside them
2 0a 0c 60
1 00 20 100
3 1c 04 20

// Second pass over rows streamed before
0 05 04 20
2 0a 0c 60
1 1e 04 20

// End of list
0 00 00 00

//--- project.f
+incdir+source
source/dram_pkg.sv
source/dram_ctrl_fsm.sv
source/dram_refresh_timer.sv
source/dram_addr_buffer.sv
source/dram_bank_array.sv
source/dram_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_dram_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_dram_subsystem -Mdir obj_dir

out=$(./obj_dir/Vtb_dram_subsystem || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
